/* Bender.yml */
package:
  name: mem_merge_sys

sources:
  - files:
      - hw/mem_merge_pkg.sv
      - hw/stream_merge.sv
      - hw/mem_merge.sv
      - hw/mem_sram.sv
      - hw/mem_response_split.sv
      - hw/mem_merge_sys.sv
  - target: test
    files:
      - dv/mem_merge_checker.sv
      - dv/mem_merge_tb.sv

/* dv/mem_merge_checker.sv */
`timescale 1ns/100ps

module mem_merge_checker
    import mem_merge_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_valid [ports],
    input  logic                    req_read [ports],
    input  logic [pre_id_width-1:0] req_id [ports],
    input  logic [meta_width-1:0]   req_meta [ports],
    input  logic                    req_ready [ports],
    input  logic [data_width-1:0]   exp_data [ports],
    input  logic                    out_valid [ports],
    input  logic [data_width-1:0]   out_data [ports],
    input  logic [pre_id_width-1:0] out_id [ports],
    input  logic [meta_width-1:0]   out_meta [ports],
    input  logic                    out_ready [ports],
    output int                      value_errors,
    output int                      other_errors,
    output int                      pending
);

    localparam int entry_width = pre_id_width + meta_width + data_width;

    // one entry {id, meta, data} per outstanding read, in issue order
    logic [entry_width-1:0] exp_q [ports][$];
    rr_state_t              last_grant;
    logic                   reset_seen;
    logic                   prev_reset;
    logic                   hold [ports];
    logic [data_width-1:0]  hold_data [ports];
    int                     cycle;
    logic                   due_armed;
    int                     due_cycle;
    int                     due_port;

    initial begin
        value_errors = 0;
        other_errors = 0;
        pending = 0;
        cycle = 0;
        due_armed = 1'b0;
        reset_seen = 1'b0;
        prev_reset = 1'b1;
        last_grant = rr_last_port1;
        for (int k = 0; k < ports; k++) begin
            hold[k] = 1'b0;
        end
    end

    task automatic compare_field(input string name, input int k,
                                 input logic [data_width-1:0] expected,
                                 input logic [data_width-1:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s[%0d] expected %h, actual %h",
                     $time, name, k, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_response(input int k);
        logic [entry_width-1:0] entry;
        if (exp_q[k].size() == 0) begin
            $display("port %0d returned a response at %0t with no read outstanding", k, $time);
            other_errors++;
        end else begin
            entry = exp_q[k].pop_front();
            compare_field("out_data", k, entry[data_width-1:0], out_data[k]);
            compare_field("out_meta", k, entry[data_width +: meta_width], out_meta[k]);
            compare_field("out_id", k, entry[data_width+meta_width +: pre_id_width], out_id[k]);
        end
    endtask

    always @(posedge clk) begin
        logic idle;
        cycle++;
        if (reset || prev_reset) begin
            for (int k = 0; k < ports; k++) begin
                if (reset_seen && out_valid[k] !== 1'b0) begin
                    $display("out_valid[%0d] high at %0t during or right after reset", k, $time);
                    other_errors++;
                end
            end
        end
        if (reset) begin
            last_grant = rr_last_port1;
            due_armed = 1'b0;
            for (int k = 0; k < ports; k++) begin
                hold[k] = 1'b0;
            end
        end else begin
            idle = (exp_q[0].size() == 0) && (exp_q[1].size() == 0);
            // read taken on an idle system shows up after the following edge
            if (due_armed && cycle == due_cycle) begin
                if (out_valid[due_port] !== 1'b1) begin
                    $display("port %0d read on an idle system has no response at %0t",
                             due_port, $time);
                    other_errors++;
                end
                due_armed = 1'b0;
            end
            for (int k = 0; k < ports; k++) begin
                if (hold[k]) begin
                    if (out_valid[k] !== 1'b1) begin
                        $display("out_valid[%0d] dropped at %0t while stalled", k, $time);
                        other_errors++;
                    end
                    compare_field("out_data", k, hold_data[k], out_data[k]);
                end
                if (out_valid[k] && out_ready[k]) begin
                    check_response(k);
                end
                hold[k] = out_valid[k] && !out_ready[k];
                hold_data[k] = out_data[k];
            end
            for (int k = 0; k < ports; k++) begin
                if (req_valid[k] && req_ready[k]) begin
                    if (req_valid[0] && req_valid[1] && k == int'(last_grant)) begin
                        $display("port %0d accepted twice in a row at %0t while both requested",
                                 k, $time);
                        other_errors++;
                    end
                    last_grant = rr_state_t'(k);
                    if (req_read[k]) begin
                        exp_q[k].push_back({req_id[k], req_meta[k], exp_data[k]});
                        if (idle) begin
                            due_armed = 1'b1;
                            due_cycle = cycle + 2;
                            due_port = k;
                        end
                    end
                end
            end
            pending = exp_q[0].size() + exp_q[1].size();
        end
        reset_seen = reset_seen || reset;
        prev_reset = reset;
    end

endmodule

/* dv/mem_merge_tb.sv */
`timescale 1ns/100ps

module mem_merge_tb
    import mem_merge_pkg::*;
();

    localparam int max_vectors = 64;

    logic                    clk;
    logic                    reset;
    logic                    req_valid [ports];
    logic                    req_read [ports];
    logic [mask_width-1:0]   req_mask [ports];
    logic [addr_width-1:0]   req_addr [ports];
    logic [data_width-1:0]   req_data [ports];
    logic [pre_id_width-1:0] req_id [ports];
    logic [meta_width-1:0]   req_meta [ports];
    logic                    req_ready [ports];
    logic                    out_valid [ports];
    logic [data_width-1:0]   out_data [ports];
    logic [pre_id_width-1:0] out_id [ports];
    logic [meta_width-1:0]   out_meta [ports];
    logic                    out_ready [ports];
    logic [data_width-1:0]   exp_data [ports];
    int                      value_errors;
    int                      other_errors;
    int                      pending;

    int                      n_vectors;
    int                      cycle_limit;
    logic                    drive_start;
    int                      drivers_done;
    int                      vec_port [max_vectors];
    mem_op_t                 vec_op [max_vectors];
    logic [addr_width-1:0]   vec_addr [max_vectors];
    logic [data_width-1:0]   vec_data [max_vectors];
    logic [mask_width-1:0]   vec_mask [max_vectors];
    logic [pre_id_width-1:0] vec_id [max_vectors];
    logic [meta_width-1:0]   vec_meta [max_vectors];
    logic [data_width-1:0]   vec_exp [max_vectors];
    int                      vec_stall [max_vectors];
    // out_ready stall per read, in the order each port issued them
    int                      stall_q [ports][$];

    mem_merge_sys i_dut (
        .clk, .reset,
        .req_valid, .req_read, .req_mask, .req_addr, .req_data, .req_id, .req_meta, .req_ready,
        .out_valid, .out_data, .out_id, .out_meta, .out_ready
    );

    mem_merge_checker i_checker (
        .clk, .reset,
        .req_valid, .req_read, .req_id, .req_meta, .req_ready, .exp_data,
        .out_valid, .out_data, .out_id, .out_meta, .out_ready,
        .value_errors, .other_errors, .pending
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic load_vectors(input int fd);
        string       line;
        int          port;
        int          op;
        int          stall;
        logic [31:0] addr, data, mask, id, meta, expv;
        n_vectors = 0;
        while (!$feof(fd) && n_vectors < max_vectors) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#" &&
                $sscanf(line, "%d %d %h %h %h %h %h %h %d",
                        port, op, addr, data, mask, id, meta, expv, stall) == 9) begin
                vec_port[n_vectors] = port;
                vec_op[n_vectors] = mem_op_t'(op);
                vec_addr[n_vectors] = addr[addr_width-1:0];
                vec_data[n_vectors] = data;
                vec_mask[n_vectors] = mask[mask_width-1:0];
                vec_id[n_vectors] = id[pre_id_width-1:0];
                vec_meta[n_vectors] = meta[meta_width-1:0];
                vec_exp[n_vectors] = expv;
                vec_stall[n_vectors] = stall;
                n_vectors++;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        int fd;
        reset = 1'b1;
        drive_start = 1'b0;
        drivers_done = 0;
        cycle_limit = 0;
        for (int k = 0; k < ports; k++) begin
            req_valid[k] = 1'b0;
            req_read[k] = 1'b0;
            req_mask[k] = '0;
            req_addr[k] = '0;
            req_data[k] = '0;
            req_id[k] = '0;
            req_meta[k] = '0;
            exp_data[k] = '0;
            out_ready[k] = 1'b1;
        end
        fd = $fopen("dv/mem_merge_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/mem_merge_vectors.txt");
            $display("TESTS FAILED");
            $finish;
        end else begin
            load_vectors(fd);
            $fclose(fd);
            cycle_limit = 20 * n_vectors + 100;
            repeat (5) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;
            drive_start = 1'b1;
            while (drivers_done < ports || pending != 0) begin
                @(negedge clk);
            end
            @(negedge clk);
            $display("vectors: %0d, errors: %0d value, %0d other",
                     n_vectors, value_errors, other_errors);
            if (n_vectors > 0 && value_errors == 0 && other_errors == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d responses still outstanding",
                 cycles, pending);
        $display("vectors: %0d, errors: %0d value, %0d other",
                 n_vectors, value_errors, other_errors);
        $display("TESTS FAILED");
        $finish;
    end

    for (genvar p = 0; p < ports; p++) begin : g_port
        // request driver, vectors of this port in file order
        initial begin
            wait (drive_start);
            for (int i = 0; i < n_vectors; i++) begin
                if (vec_port[i] == p) begin
                    @(negedge clk);
                    if (vec_op[i] == mem_op_idle) begin
                        req_valid[p] = 1'b0;
                        repeat (vec_stall[i]) @(negedge clk);
                    end else begin
                        req_read[p] = (vec_op[i] == mem_op_read);
                        req_mask[p] = vec_mask[i];
                        req_addr[p] = vec_addr[i];
                        req_data[p] = vec_data[i];
                        req_id[p] = vec_id[i];
                        req_meta[p] = vec_meta[i];
                        exp_data[p] = vec_exp[i];
                        req_valid[p] = 1'b1;
                        do @(posedge clk); while (!req_ready[p]);
                        if (vec_op[i] == mem_op_read) begin
                            stall_q[p].push_back(vec_stall[i]);
                        end
                    end
                end
            end
            @(negedge clk);
            req_valid[p] = 1'b0;
            drivers_done++;
        end

        // response side, vector stall plus an occasional random one
        initial begin
            logic [31:0] rng;
            int          stall;
            logic        loaded;
            rng = 32'd30;
            stall = 0;
            loaded = 1'b0;
            wait (drive_start);
            forever begin
                @(negedge clk);
                if (out_valid[p] && !loaded) begin
                    rng = xorshift(rng);
                    stall = 0;
                    if (stall_q[p].size() > 0) begin
                        stall = stall_q[p].pop_front();
                    end
                    if (rng[1:0] == 2'b00) begin
                        stall += 1 + int'(rng[2]);
                    end
                    loaded = 1'b1;
                end
                out_ready[p] = (stall == 0);
                if (stall > 0) begin
                    stall--;
                end
                @(posedge clk);
                if (out_valid[p] && out_ready[p]) begin
                    loaded = 1'b0;
                end
            end
        end
    end

endmodule

/* dv/mem_merge_vectors.txt */
# port op(0 idle, 1 read, 2 write) addr data mask id meta expected_read_data stall
# port 0 owns addresses 00-7f and port 1 owns 80-ff; stall counts cycles for reads and idles
0 2 10 11223344 f 0 0 00000000 0
1 2 90 01020304 f 0 0 00000000 0
0 2 10 aabbccdd 3 1 1 00000000 0
1 2 90 ffffffff 2 0 0 00000000 0
0 1 10 00000000 0 2 3 1122ccdd 2
1 1 90 00000000 0 3 2 0102ff04 4
0 2 11 deadbeef f 1 2 00000000 0
1 2 a0 12345678 f 1 1 00000000 0
0 2 11 00550000 4 3 0 00000000 0
1 2 a0 00abcd00 6 2 1 00000000 0
0 1 11 00000000 0 3 1 de55beef 0
1 1 a0 00000000 0 1 0 12abcd78 1
0 2 12 cafef00d f 0 0 00000000 0
1 2 ff 87654321 f 0 3 00000000 0
0 2 12 99000077 9 0 0 00000000 0
1 2 ff 0000ee00 2 0 3 00000000 0
0 1 12 00000000 0 1 2 99fef077 3
1 1 ff 00000000 0 2 1 8765ee21 0
0 1 10 00000000 0 0 0 1122ccdd 0
1 1 90 00000000 0 0 3 0102ff04 2
0 0 00 00000000 0 0 0 00000000 15
0 1 11 00000000 0 2 3 de55beef 0

/* hw/mem_merge.sv */
`timescale 1ns/100ps

module mem_merge
    import mem_merge_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    req_valid [ports],
    input  logic                    req_read [ports],
    input  logic [mask_width-1:0]   req_mask [ports],
    input  logic [addr_width-1:0]   req_addr [ports],
    input  logic [data_width-1:0]   req_data [ports],
    input  logic [pre_id_width-1:0] req_id [ports],
    input  logic [meta_width-1:0]   req_meta [ports],
    output logic                    req_ready [ports],

    output logic                    mem_valid,
    output logic                    mem_read,
    output logic [mask_width-1:0]   mem_mask,
    output logic [addr_width-1:0]   mem_addr,
    output logic [data_width-1:0]   mem_data,
    output logic [id_width-1:0]     mem_id,
    output logic [meta_width-1:0]   mem_meta,
    input  logic                    mem_ready
);

    logic [payload_width-1:0] in_payload [ports];
    logic [payload_width-1:0] out_payload;
    logic [port_id_width-1:0] out_port;
    logic [pre_id_width-1:0]  pre_id;

    generate
        genvar k;
        for (k = 0; k < ports; k++) begin : g_pack
            assign in_payload[k] = {req_read[k], req_mask[k], req_addr[k],
                                    req_data[k], req_id[k], req_meta[k]};

            // reads carry no byte mask
            a_read_no_mask: assert property (
                @(posedge clk) disable iff (reset)
                req_valid[k] |-> !(req_read[k] && (|req_mask[k]))
            ) else $error("mem_merge: port %0d read with nonzero mask", k);
        end
    endgenerate

    stream_merge stream_merge_inst (
        .clk,
        .reset,
        .in_valid    (req_valid),
        .in_payload  (in_payload),
        .in_ready    (req_ready),
        .out_valid   (mem_valid),
        .out_payload (out_payload),
        .out_port    (out_port),
        .out_ready   (mem_ready)
    );

    assign {mem_read, mem_mask, mem_addr, mem_data, pre_id, mem_meta} = out_payload;

    // port index goes above the requester id
    assign mem_id = {out_port, pre_id};

endmodule

/* hw/mem_merge_pkg.sv */
package mem_merge_pkg;

    // requester ports and the bits that name one
    localparam int ports = 2;
    localparam int port_id_width = 1;

    // word addressed, 256 words
    localparam int addr_width = 8;
    localparam int data_width = 32;
    localparam int mask_width = 4;

    localparam int pre_id_width = 2;
    localparam int id_width = pre_id_width + port_id_width;
    localparam int meta_width = 2;

    // read enable, mask, addr, data, id, meta
    localparam int payload_width = 1 + mask_width + addr_width + data_width
                                   + pre_id_width + meta_width;

    typedef enum logic [1:0] {
        mem_op_idle,
        mem_op_read,
        mem_op_write
    } mem_op_t;

    // one value per port, names the port granted last
    typedef enum logic [port_id_width-1:0] {
        rr_last_port0,
        rr_last_port1
    } rr_state_t;

endpackage

/* hw/mem_merge_sys.sv */
`timescale 1ns/100ps

module mem_merge_sys
    import mem_merge_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    req_valid [ports],
    input  logic                    req_read [ports],
    input  logic [mask_width-1:0]   req_mask [ports],
    input  logic [addr_width-1:0]   req_addr [ports],
    input  logic [data_width-1:0]   req_data [ports],
    input  logic [pre_id_width-1:0] req_id [ports],
    input  logic [meta_width-1:0]   req_meta [ports],
    output logic                    req_ready [ports],

    output logic                    out_valid [ports],
    output logic [data_width-1:0]   out_data [ports],
    output logic [pre_id_width-1:0] out_id [ports],
    output logic [meta_width-1:0]   out_meta [ports],
    input  logic                    out_ready [ports]
);

    // merged request stream
    logic                  mem_valid;
    logic                  mem_read;
    logic [mask_width-1:0] mem_mask;
    logic [addr_width-1:0] mem_addr;
    logic [data_width-1:0] mem_data;
    logic [id_width-1:0]   mem_id;
    logic [meta_width-1:0] mem_meta;
    logic                  mem_ready;

    // read responses before the split
    logic                  rsp_valid;
    logic [data_width-1:0] rsp_data;
    logic [id_width-1:0]   rsp_id;
    logic [meta_width-1:0] rsp_meta;
    logic                  rsp_ready;

    mem_merge mem_merge_inst (
        .clk, .reset,
        .req_valid, .req_read, .req_mask, .req_addr, .req_data, .req_id, .req_meta, .req_ready,
        .mem_valid, .mem_read, .mem_mask, .mem_addr, .mem_data, .mem_id, .mem_meta, .mem_ready
    );

    mem_sram mem_sram_inst (
        .clk, .reset,
        .mem_valid, .mem_read, .mem_mask, .mem_addr, .mem_data, .mem_id, .mem_meta, .mem_ready,
        .rsp_valid, .rsp_data, .rsp_id, .rsp_meta, .rsp_ready
    );

    mem_response_split mem_response_split_inst (
        .rsp_valid, .rsp_data, .rsp_id, .rsp_meta, .rsp_ready,
        .out_valid, .out_data, .out_id, .out_meta, .out_ready
    );

endmodule

/* hw/mem_response_split.sv */
`timescale 1ns/100ps

module mem_response_split
    import mem_merge_pkg::*;
(
    input  logic                    rsp_valid,
    input  logic [data_width-1:0]   rsp_data,
    input  logic [id_width-1:0]     rsp_id,
    input  logic [meta_width-1:0]   rsp_meta,
    output logic                    rsp_ready,

    output logic                    out_valid [ports],
    output logic [data_width-1:0]   out_data [ports],
    output logic [pre_id_width-1:0] out_id [ports],
    output logic [meta_width-1:0]   out_meta [ports],
    input  logic                    out_ready [ports]
);

    logic [port_id_width-1:0] port_sel;
    logic [ports-1:0]         valid_vec;

    // upper id bits name the port that issued the read
    assign port_sel = rsp_id[id_width-1 -: port_id_width];

    generate
        genvar k;
        for (k = 0; k < ports; k++) begin : g_split
            assign out_valid[k] = rsp_valid && (port_sel == port_id_width'(k));
            assign out_data[k] = rsp_data;
            assign out_id[k] = rsp_id[pre_id_width-1:0];
            assign out_meta[k] = rsp_meta;
            assign valid_vec[k] = out_valid[k];
        end
    endgenerate

    assign rsp_ready = out_ready[port_sel];

    a_one_port: assert final ($onehot0(valid_vec))
        else $error("mem_response_split: response on more than one port");

endmodule

/* hw/mem_sram.sv */
`timescale 1ns/100ps

module mem_sram
    import mem_merge_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  mem_valid,
    input  logic                  mem_read,
    input  logic [mask_width-1:0] mem_mask,
    input  logic [addr_width-1:0] mem_addr,
    input  logic [data_width-1:0] mem_data,
    input  logic [id_width-1:0]   mem_id,
    input  logic [meta_width-1:0] mem_meta,
    output logic                  mem_ready,

    output logic                  rsp_valid,
    output logic [data_width-1:0] rsp_data,
    output logic [id_width-1:0]   rsp_id,
    output logic [meta_width-1:0] rsp_meta,
    input  logic                  rsp_ready
);

    logic [data_width-1:0] mem_array [2**addr_width];
    mem_op_t               op;

    // room for a new read once the response register drains
    assign mem_ready = !rsp_valid || rsp_ready;

    always_comb begin
        if (!(mem_valid && mem_ready)) begin
            op = mem_op_idle;
        end else if (mem_read) begin
            op = mem_op_read;
        end else begin
            op = mem_op_write;
        end
    end

    // only the masked bytes change
    always_ff @(posedge clk) begin
        if (op == mem_op_write) begin
            for (int b = 0; b < mask_width; b++) begin
                if (mem_mask[b]) begin
                    mem_array[mem_addr][b*8 +: 8] <= mem_data[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (op == mem_op_read) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (op == mem_op_read) begin
            rsp_data <= mem_array[mem_addr];
            rsp_id <= mem_id;
            rsp_meta <= mem_meta;
        end
    end

    a_rsp_hold: assert property (
        @(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data) && $stable(rsp_id)
    ) else $error("mem_sram: response dropped before rsp_ready");

endmodule

/* hw/stream_merge.sv */
`timescale 1ns/100ps

module stream_merge
    import mem_merge_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,

    input  logic                     in_valid [ports],
    input  logic [payload_width-1:0] in_payload [ports],
    output logic                     in_ready [ports],

    output logic                     out_valid,
    output logic [payload_width-1:0] out_payload,
    output logic [port_id_width-1:0] out_port,
    input  logic                     out_ready
);

    rr_state_t                rr_last;
    logic                     grant_valid;
    logic [port_id_width-1:0] grant_port;
    logic                     load;

    // search starts one past the last granted port and wraps around
    always_comb begin
        automatic int idx;
        grant_valid = 1'b0;
        grant_port = '0;
        for (int i = 1; i <= ports; i++) begin
            idx = (int'(rr_last) + i) % ports;
            if (!grant_valid && in_valid[idx]) begin
                grant_valid = 1'b1;
                grant_port = port_id_width'(idx);
            end
        end
    end

    // output register free, or emptied on this edge
    assign load = grant_valid && (!out_valid || out_ready);

    generate
        genvar k;
        for (k = 0; k < ports; k++) begin : g_ready
            assign in_ready[k] = load && (grant_port == port_id_width'(k));
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            rr_last <= rr_last_port1;
        end else if (load) begin
            out_valid <= 1'b1;
            rr_last <= rr_state_t'(grant_port);
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_payload <= in_payload[grant_port];
            out_port <= grant_port;
        end
    end

    // a stalled output keeps its payload and port until it leaves
    a_out_hold: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_payload) && $stable(out_port)
    ) else $error("stream_merge: output changed while stalled");

endmodule

/* mem_merge_sys.f */
hw/mem_merge_pkg.sv
hw/stream_merge.sv
hw/mem_merge.sv
hw/mem_sram.sv
hw/mem_response_split.sv
hw/mem_merge_sys.sv
dv/mem_merge_checker.sv
dv/mem_merge_tb.sv
